/* common/arcade_ctrl_pkg.sv */
// ----------------------------------------
// Shared types for the control-input path
// Key positions in the membrane vector
// Matrix scan and debounce timing
// ----------------------------------------

`default_nettype none

package arcade_ctrl_pkg;

	// ----------------------------------------
	// Control vectors, all active high
	// ----------------------------------------

	// Fire B, fire A, up, down, left, right
	typedef logic [5:0] joy_t;

	// Patrons, start 2, start 1, coin, fire B, fire A, up, down, left, right
	typedef logic [9:0] membrane_t;

	// Start 2, start 1, coin, fire B, fire A, up, down, left, right
	typedef logic [8:0] player_t;

	// Link payload, player 1 in the upper half
	typedef struct packed {
		player_t p1_word;
		player_t p2_word;
	} ctrl_pair_t;

	// ----------------------------------------
	// Membrane key positions
	// ----------------------------------------
	localparam int KEY_COIN    = 6;
	localparam int KEY_START1  = 7;
	localparam int KEY_START2  = 8;
	localparam int KEY_PATRONS = 9;

	// Keys 8 and 9 live on column 1 of rows 0 and 1
	localparam int MEMB_COL1_BASE = 8;
	localparam int MEMB_COL1_ROWS = 2;

	// ----------------------------------------
	// Matrix scan and filter timing
	// ----------------------------------------
	localparam int KEYB_ROWS = 8;
	localparam int KEYB_COLS = 7;
	localparam int SCAN_DWELL = 4;
	localparam int DEBOUNCE_CYCLES = 8;

	localparam int ROW_W = $clog2(KEYB_ROWS);
	localparam int DWELL_W = $clog2(SCAN_DWELL);
	localparam int DEBOUNCE_W = $clog2(DEBOUNCE_CYCLES + 1);

endpackage

`default_nettype wire

/* ctrl_input/joy_mux_sampler.sv */
// ----------------------------------------
// Joystick port multiplexer
// Drives the select line, captures both ports
// ----------------------------------------

`default_nettype none

module joy_mux_sampler
	import arcade_ctrl_pkg::*;
(
	input  logic       btn_patrons_s,
	input  logic       arst_n_i,
	input  logic [5:0] joyp_n_i,
	output logic       joysel_o,
	output joy_t       joy1_raw_o,
	output joy_t       joy2_raw_o
);

	// Pins are active low, the vectors are active high
	joy_t port_sample;

	assign port_sample = ~joyp_n_i;

	// Select flips every cycle, both sockets share the pins
	always_ff @(posedge btn_patrons_s or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			joysel_o   <= 1'b0;
			joy1_raw_o <= '0;
			joy2_raw_o <= '0;
		end
		else
		begin
			joysel_o <= ~joysel_o;

			// Route by the select value seen while sampling
			if (!joysel_o)
			begin
				joy1_raw_o <= port_sample;
			end
			else
			begin
				joy2_raw_o <= port_sample;
			end
		end
	end

endmodule

`default_nettype wire

/* ctrl_input/membrane_scanner.sv */
// ----------------------------------------
// Membrane keyboard matrix scanner
// Row drive, column sampling, key vector
// ----------------------------------------

`default_nettype none

module membrane_scanner
	import arcade_ctrl_pkg::*;
(
	input  logic                 btn_patrons_s,
	input  logic                 arst_n_i,
	input  logic [KEYB_COLS-1:0] keyb_col_i,
	output logic [KEYB_ROWS-1:0] keyb_row_o,
	output membrane_t            memb_raw_o
);

	logic [DWELL_W-1:0] dwell_q;
	logic [ROW_W-1:0]   row_q;
	logic               sample_now;
	logic               sweep_end;
	membrane_t          shadow_q;
	membrane_t          shadow_next;

	// Active row pulled low, all others high
	assign keyb_row_o = ~({{(KEYB_ROWS-1){1'b0}}, 1'b1} << row_q);

	assign sample_now = (dwell_q == DWELL_W'(SCAN_DWELL - 1));
	assign sweep_end  = sample_now && (row_q == ROW_W'(KEYB_ROWS - 1));

	// ----------------------------------------
	// Key placement for the current row
	// ----------------------------------------
	always_comb
	begin
		shadow_next = shadow_q;
		if (sample_now)
		begin
			// Column 0 carries key number equal to the row
			shadow_next[row_q] = ~keyb_col_i[0];

			// Column 1 only used on the first rows
			if (row_q < ROW_W'(MEMB_COL1_ROWS))
			begin
				shadow_next[MEMB_COL1_BASE + int'(row_q)] = ~keyb_col_i[1];
			end
		end
	end

	// Shadow vector of the sweep in progress
	always_ff @(posedge btn_patrons_s or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			shadow_q <= '0;
		end
		else
		begin
			shadow_q <= shadow_next;
		end
	end

	// ----------------------------------------
	// Dwell counter and row stepping
	// ----------------------------------------
	always_ff @(posedge btn_patrons_s or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			dwell_q    <= '0;
			row_q      <= '0;
			memb_raw_o <= '0;
		end
		else
		begin
			dwell_q <= sample_now ? '0 : dwell_q + 1'b1;

			if (sweep_end)
			begin
				row_q      <= '0;
				memb_raw_o <= shadow_next;
			end
			else if (sample_now)
			begin
				row_q <= row_q + 1'b1;
			end
		end
	end

	// Exactly one row driven at any time
	a_one_row_low: assert property (@(posedge btn_patrons_s) disable iff (!arst_n_i)
		$onehot(~keyb_row_o));

endmodule

`default_nettype wire

/* src/debounce_filter.sv */
// ----------------------------------------
// Stability filter for button vectors
// One debounce length for every payload
// ----------------------------------------

`default_nettype none

module debounce_filter
	import arcade_ctrl_pkg::*;
#(
	parameter type payload_t = logic
)
(
	input  logic     btn_patrons_s,
	input  logic     arst_n_i,
	input  payload_t raw_i,
	output payload_t clean_o
);

	payload_t              raw_q;
	logic [DEBOUNCE_W-1:0] stable_q;
	logic [DEBOUNCE_W-1:0] stable_next;

	// Count of consecutive cycles with the same input value
	always_comb
	begin
		if (raw_i != raw_q)
		begin
			// First cycle of a new value
			stable_next = DEBOUNCE_W'(1);
		end
		else if (stable_q != DEBOUNCE_W'(DEBOUNCE_CYCLES))
		begin
			stable_next = stable_q + 1'b1;
		end
		else
		begin
			stable_next = stable_q;
		end
	end

	always_ff @(posedge btn_patrons_s or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			raw_q    <= '0;
			stable_q <= '0;
			clean_o  <= '0;
		end
		else
		begin
			raw_q    <= raw_i;
			stable_q <= stable_next;

			// Held long enough, follow the input
			if (stable_next == DEBOUNCE_W'(DEBOUNCE_CYCLES))
			begin
				clean_o <= raw_i;
			end
		end
	end

endmodule

`default_nettype wire

/* src/control_merge.sv */
// ----------------------------------------
// Player word merge and toggle settings
// Patrons overlay and scan-doubler enable
// ----------------------------------------

`default_nettype none

module control_merge
	import arcade_ctrl_pkg::*;
(
	input  logic       btn_patrons_s,
	input  logic       arst_n_i,
	input  joy_t       joy1_i,
	input  joy_t       joy2_i,
	input  membrane_t  memb_i,
	input  logic       multiface_i,
	output ctrl_pair_t pair_word_o,
	output logic       patrons_o,
	output logic       scandbl_o
);

	player_t    p1_merged;
	player_t    p2_merged;
	logic       patrons_key_q;
	logic       multiface_q;
	logic       patrons_rise;
	logic       multiface_rise;

	// ----------------------------------------
	// Player words
	// ----------------------------------------

	// Membrane directions and fire keys act as a second player 1 stick
	assign p1_merged = {memb_i[KEY_START2], memb_i[KEY_START1], memb_i[KEY_COIN],
		joy1_i | memb_i[5:0]};

	// No coin or start keys for player 2
	assign p2_merged = {3'b000, joy2_i};

	assign patrons_rise   = memb_i[KEY_PATRONS] && !patrons_key_q;
	assign multiface_rise = multiface_i && !multiface_q;

	always_ff @(posedge btn_patrons_s or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			pair_word_o <= '0;
		end
		else
		begin
			pair_word_o.p1_word <= p1_merged;
			pair_word_o.p2_word <= p2_merged;
		end
	end

	// ----------------------------------------
	// Toggle settings
	// ----------------------------------------
	always_ff @(posedge btn_patrons_s or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			patrons_key_q <= 1'b0;
			multiface_q   <= 1'b0;
			patrons_o     <= 1'b0;
			scandbl_o     <= 1'b0;
		end
		else
		begin
			patrons_key_q <= memb_i[KEY_PATRONS];
			multiface_q   <= multiface_i;

			// One flip per press
			if (patrons_rise)
			begin
				patrons_o <= ~patrons_o;
			end
			if (multiface_rise)
			begin
				scandbl_o <= ~scandbl_o;
			end
		end
	end

endmodule

`default_nettype wire

/* ctrl_output/ctrl_word_sender.sv */
// ----------------------------------------
// Four-phase req/ack sender
// Sends only words that changed
// ----------------------------------------

`default_nettype none

module ctrl_word_sender
	import arcade_ctrl_pkg::*;
(
	input  logic       btn_patrons_s,
	input  logic       arst_n_i,
	input  ctrl_pair_t pair_word_i,
	input  logic       ctrl_ack_i,
	output logic       ctrl_req_o,
	output ctrl_pair_t ctrl_data_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LATCH,
		ST_REQ,
		ST_ACK_LOW
	} state_t;

	state_t     state_q;
	ctrl_pair_t sent_q;

	// The latched word is both the payload and the last word sent
	assign ctrl_data_o = sent_q;
	assign ctrl_req_o  = (state_q == ST_REQ);

	always_ff @(posedge btn_patrons_s or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= ST_IDLE;
			sent_q  <= '0;
		end
		else
		begin
			case (state_q)
				ST_IDLE:
				begin
					// Only the value present right now, nothing queued
					if (pair_word_i != sent_q)
					begin
						sent_q  <= pair_word_i;
						state_q <= ST_LATCH;
					end
				end
				ST_LATCH:
				begin
					state_q <= ST_REQ;
				end
				ST_REQ:
				begin
					if (ctrl_ack_i)
					begin
						state_q <= ST_ACK_LOW;
					end
				end
				ST_ACK_LOW:
				begin
					// Core must release ack before the next word
					if (!ctrl_ack_i)
					begin
						state_q <= ST_IDLE;
					end
				end
				default:
				begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------
	// Handshake rules
	// ----------------------------------------
	a_data_stable: assert property (@(posedge btn_patrons_s) disable iff (!arst_n_i)
		ctrl_req_o && $past(ctrl_req_o) |-> $stable(ctrl_data_o));

	a_req_fall_acked: assert property (@(posedge btn_patrons_s) disable iff (!arst_n_i)
		$fell(ctrl_req_o) |-> $past(ctrl_ack_i));

endmodule

`default_nettype wire

/* src/arcade_ctrl_top.sv */
// ----------------------------------------
// Control-input subsystem top level
// Sampling, debounce, merge and link
// ----------------------------------------

`default_nettype none

module arcade_ctrl_top
	import arcade_ctrl_pkg::*;
(
	input  logic                 btn_patrons_s,
	input  logic                 arst_n_i,
	input  logic [5:0]           joyp_n_i,
	output logic                 joysel_o,
	input  logic [KEYB_COLS-1:0] keyb_col_i,
	output logic [KEYB_ROWS-1:0] keyb_row_o,
	input  logic                 btn_multiface_n_i,
	output logic                 ctrl_req_o,
	input  logic                 ctrl_ack_i,
	output ctrl_pair_t           ctrl_data_o,
	output logic                 patrons_o,
	output logic                 scandbl_o
);

	joy_t       joy1_raw;
	joy_t       joy2_raw;
	joy_t       joy1;
	joy_t       joy2;
	membrane_t  memb_raw;
	membrane_t  memb;
	logic [1:0] multiface_sync;
	logic       multiface;
	ctrl_pair_t pair_word;

	// ----------------------------------------
	// Input side
	// ----------------------------------------
	joy_mux_sampler u_joy_mux (
		.btn_patrons_s (btn_patrons_s),
		.arst_n_i      (arst_n_i),
		.joyp_n_i      (joyp_n_i),
		.joysel_o      (joysel_o),
		.joy1_raw_o    (joy1_raw),
		.joy2_raw_o    (joy2_raw)
	);

	membrane_scanner u_membrane (
		.btn_patrons_s (btn_patrons_s),
		.arst_n_i      (arst_n_i),
		.keyb_col_i    (keyb_col_i),
		.keyb_row_o    (keyb_row_o),
		.memb_raw_o    (memb_raw)
	);

	// Multiface button is asynchronous to the board clock
	always_ff @(posedge btn_patrons_s or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			multiface_sync <= 2'b00;
		end
		else
		begin
			multiface_sync <= {multiface_sync[0], ~btn_multiface_n_i};
		end
	end

	// ----------------------------------------
	// Debounce and merge
	// ----------------------------------------
	debounce_filter #(.payload_t(joy_t)) u_deb_joy1 (
		.btn_patrons_s (btn_patrons_s),
		.arst_n_i      (arst_n_i),
		.raw_i         (joy1_raw),
		.clean_o       (joy1)
	);

	debounce_filter #(.payload_t(joy_t)) u_deb_joy2 (
		.btn_patrons_s (btn_patrons_s),
		.arst_n_i      (arst_n_i),
		.raw_i         (joy2_raw),
		.clean_o       (joy2)
	);

	debounce_filter #(.payload_t(membrane_t)) u_deb_memb (
		.btn_patrons_s (btn_patrons_s),
		.arst_n_i      (arst_n_i),
		.raw_i         (memb_raw),
		.clean_o       (memb)
	);

	debounce_filter #(.payload_t(logic)) u_deb_multiface (
		.btn_patrons_s (btn_patrons_s),
		.arst_n_i      (arst_n_i),
		.raw_i         (multiface_sync[1]),
		.clean_o       (multiface)
	);

	control_merge u_merge (
		.btn_patrons_s (btn_patrons_s),
		.arst_n_i      (arst_n_i),
		.joy1_i        (joy1),
		.joy2_i        (joy2),
		.memb_i        (memb),
		.multiface_i   (multiface),
		.pair_word_o   (pair_word),
		.patrons_o     (patrons_o),
		.scandbl_o     (scandbl_o)
	);

	// ----------------------------------------
	// Output side
	// ----------------------------------------
	ctrl_word_sender u_sender (
		.btn_patrons_s (btn_patrons_s),
		.arst_n_i      (arst_n_i),
		.pair_word_i   (pair_word),
		.ctrl_ack_i    (ctrl_ack_i),
		.ctrl_req_o    (ctrl_req_o),
		.ctrl_data_o   (ctrl_data_o)
	);

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// ----------------------------------------
// Testbench clock and reset generator
// ----------------------------------------

`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 3
)
(
	output logic clk_o,
	output logic arst_n_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
		begin
			#(PERIOD / 2) clk_o = ~clk_o;
		end
	end

	// Reset released on a falling edge, like every other input
	initial
	begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

/* testbench/arcade_ctrl_tb.sv */
// ----------------------------------------
// Testbench for the control-input top
// Joystick, matrix and ack responders
// Reference model, compare tasks, timeout
// ----------------------------------------

`default_nettype none

module arcade_ctrl_tb
	import arcade_ctrl_pkg::*;
();

	localparam int NUM_PHASES     = 40;
	localparam int PHASE_CYCLES   = 150;
	localparam int TIMEOUT_CYCLES = NUM_PHASES * PHASE_CYCLES + 500;
	localparam int ACK_DELAYS     = 256;

	logic                 btn_patrons_s;
	logic                 arst_n;
	logic [5:0]           joyp_n;
	logic                 joysel;
	logic [KEYB_COLS-1:0] keyb_col;
	logic [KEYB_ROWS-1:0] keyb_row;
	logic                 btn_multiface_n;
	logic                 ctrl_req;
	logic                 ctrl_ack;
	ctrl_pair_t           ctrl_data;
	logic                 patrons;
	logic                 scandbl;

	// Steady stimulus and short bounce masks on top of it
	joy_t      stim_joy1;
	joy_t      stim_joy2;
	membrane_t stim_keys;
	logic      stim_multiface;
	joy_t      glitch_joy1;
	joy_t      glitch_joy2;
	membrane_t glitch_keys;
	logic      glitch_mf;

	// Model and monitor state
	int unsigned ack_delay [ACK_DELAYS];
	int unsigned ack_idx = 0;
	int unsigned patrons_presses = 0;
	int unsigned multiface_presses = 0;
	int unsigned xfer_count = 0;
	int unsigned cycle_count = 0;
	logic        prev_key9 = 1'b0;
	logic        prev_mf = 1'b0;
	logic        monitor_on = 1'b0;
	logic        prev_valid = 1'b0;
	logic        prev_joysel;
	logic        prev_req;
	ctrl_pair_t  prev_data;
	ctrl_pair_t  last_xfer = '0;
	logic        ack_seen = 1'b0;
	logic        seen_patrons = 1'b0;
	logic        seen_scandbl = 1'b0;

	tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) u_clock_gen (
		.clk_o    (btn_patrons_s),
		.arst_n_o (arst_n)
	);

	arcade_ctrl_top u_dut (
		.btn_patrons_s     (btn_patrons_s),
		.arst_n_i          (arst_n),
		.joyp_n_i          (joyp_n),
		.joysel_o          (joysel),
		.keyb_col_i        (keyb_col),
		.keyb_row_o        (keyb_row),
		.btn_multiface_n_i (btn_multiface_n),
		.ctrl_req_o        (ctrl_req),
		.ctrl_ack_i        (ctrl_ack),
		.ctrl_data_o       (ctrl_data),
		.patrons_o         (patrons),
		.scandbl_o         (scandbl)
	);

	// ----------------------------------------
	// Reporting and compare tasks
	// ----------------------------------------
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "stopping after the first error");
	endtask

	task automatic check_pair(input string name, input ctrl_pair_t actual,
		input ctrl_pair_t expected);
		if (actual !== expected)
		begin
			abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			abort_run($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, name, actual, expected));
		end
	endtask

	// ----------------------------------------
	// Reference model
	// ----------------------------------------

	// Player 1 gets coin and starts, directions and fire are ORed
	function automatic ctrl_pair_t expected_pair(input joy_t j1, input joy_t j2,
		input membrane_t k);
		ctrl_pair_t word;
		word.p1_word = {k[8], k[7], k[6], j1 | k[5:0]};
		word.p2_word = {3'b000, j2};
		return word;
	endfunction

	// Key i on row i column 0, keys 8 and 9 on rows 0 and 1 column 1
	function automatic logic [KEYB_COLS-1:0] matrix_columns(input membrane_t pressed,
		input logic [KEYB_ROWS-1:0] rows_n);
		logic [KEYB_COLS-1:0] cols;
		cols = '1;
		for (int r = 0; r < KEYB_ROWS; r++)
		begin
			if (!rows_n[r])
			begin
				if (pressed[r])
				begin
					cols[0] = 1'b0;
				end
				if (r < 2)
				begin
					if (pressed[8 + r])
					begin
						cols[1] = 1'b0;
					end
				end
			end
		end
		return cols;
	endfunction

	// ----------------------------------------
	// Responders, all driving on the falling edge
	// ----------------------------------------
	always @(negedge btn_patrons_s)
	begin
		if (joysel)
		begin
			joyp_n = ~(stim_joy2 ^ glitch_joy2);
		end
		else
		begin
			joyp_n = ~(stim_joy1 ^ glitch_joy1);
		end
		keyb_col        = matrix_columns(stim_keys ^ glitch_keys, keyb_row);
		btn_multiface_n = ~(stim_multiface ^ glitch_mf);
	end

	// Game core side of the link, slow by a random number of cycles
	initial
	begin
		int unsigned delay;
		ctrl_ack = 1'b0;
		forever
		begin
			@(negedge btn_patrons_s);
			if (ctrl_req && !ctrl_ack)
			begin
				delay   = ack_delay[ack_idx];
				ack_idx = (ack_idx + 1) % ACK_DELAYS;
				repeat (delay) @(negedge btn_patrons_s);
				ctrl_ack = 1'b1;
			end
			else if (!ctrl_req && ctrl_ack)
			begin
				delay   = ack_delay[ack_idx];
				ack_idx = (ack_idx + 1) % ACK_DELAYS;
				repeat (delay) @(negedge btn_patrons_s);
				ctrl_ack = 1'b0;
			end
		end
	end

	// ----------------------------------------
	// Handshake and output monitor
	// ----------------------------------------

	// Ack as the sender sees it on the rising edge
	always @(posedge btn_patrons_s)
	begin
		ack_seen <= ctrl_ack;
	end

	always @(negedge btn_patrons_s)
	begin
		if (monitor_on)
		begin
			if ($countones(~keyb_row) != 1)
			begin
				abort_run("keyb_row_o does not drive exactly one row low");
			end
			if (!prev_valid)
			begin
				check_bit("ctrl_req_o", ctrl_req, 1'b0);
				check_bit("patrons_o", patrons, 1'b0);
				check_bit("scandbl_o", scandbl, 1'b0);
			end
			else
			begin
				check_bit("joysel_o", joysel, ~prev_joysel);
				if (prev_req && ctrl_req)
				begin
					check_pair("ctrl_data_o", ctrl_data, prev_data);
				end
				if (!prev_req && ctrl_req && ack_seen)
				begin
					abort_run("ctrl_req_o rose while ctrl_ack_i was still high");
				end
				// Transfer ends when req falls
				if (prev_req && !ctrl_req)
				begin
					if (!ack_seen)
					begin
						abort_run("ctrl_req_o fell before ctrl_ack_i was seen high");
					end
					if (prev_data == last_xfer)
					begin
						abort_run("a transfer repeated the previous word");
					end
					last_xfer = prev_data;
					xfer_count++;
				end
			end
			prev_valid   = 1'b1;
			prev_joysel  = joysel;
			prev_req     = ctrl_req;
			prev_data    = ctrl_data;
			seen_patrons = patrons;
			seen_scandbl = scandbl;
		end
	end

	always @(posedge btn_patrons_s)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			abort_run("timeout, the run did not finish within the cycle limit");
		end
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	// Bounces shorter than the debounce length
	task automatic inject_glitches(output int unsigned used);
		int unsigned len;
		int unsigned pick;
		logic        row_hit;
		logic        last_row;
		used = 0;
		repeat (4) @(posedge btn_patrons_s);
		used += 4;

		// Joystick pin held at most three samples
		len  = 1 + $urandom % 5;
		pick = $urandom % 12;
		if (pick < 6)
		begin
			glitch_joy1 = joy_t'(1) << pick;
		end
		else
		begin
			glitch_joy2 = joy_t'(1) << (pick - 6);
		end
		repeat (len) @(posedge btn_patrons_s);
		glitch_joy1 = '0;
		glitch_joy2 = '0;
		repeat (DEBOUNCE_CYCLES) @(posedge btn_patrons_s);
		used += len + DEBOUNCE_CYCLES;

		len       = 1 + $urandom % (DEBOUNCE_CYCLES - 1);
		glitch_mf = 1'b1;
		repeat (len) @(posedge btn_patrons_s);
		glitch_mf = 1'b0;
		repeat (DEBOUNCE_CYCLES) @(posedge btn_patrons_s);
		used += len + DEBOUNCE_CYCLES;

		// Wait for the first dwell cycle of row 0
		row_hit  = 1'b0;
		last_row = 1'b0;
		while (!row_hit)
		begin
			@(negedge btn_patrons_s);
			row_hit  = last_row && (keyb_row[0] == 1'b0);
			last_row = (keyb_row[KEYB_ROWS-1] == 1'b0);
			@(posedge btn_patrons_s);
			used++;
		end

		// Key bounce on row 1, gone before its columns are read
		if (($urandom % 2) != 0)
		begin
			glitch_keys = membrane_t'(1) << KEY_PATRONS;
		end
		else
		begin
			glitch_keys = membrane_t'(1) << 1;
		end
		len = 1 + $urandom % (2 * SCAN_DWELL - 2);
		repeat (len) @(posedge btn_patrons_s);
		glitch_keys = '0;
		used += len;
	endtask

	task automatic run_phase(input int idx);
		int unsigned used;
		int unsigned xfers_before;
		used = 0;
		case (idx % 4)
			0:
			begin
				stim_joy1      = joy_t'($urandom);
				stim_joy2      = joy_t'($urandom);
				stim_keys      = '0;
				stim_multiface = 1'b0;
			end
			1:
			begin
				stim_joy1      = joy_t'($urandom);
				stim_joy2      = joy_t'($urandom);
				stim_keys      = membrane_t'($urandom);
				stim_multiface = 1'b0;
			end
			2:
			begin
				stim_keys[9]   = ($urandom % 2) != 0;
				stim_multiface = ($urandom % 2) != 0;
			end
			default:
			begin
			end
		endcase

		// Each new press flips its setting once
		if (stim_keys[9] && !prev_key9)
		begin
			patrons_presses++;
		end
		if (stim_multiface && !prev_mf)
		begin
			multiface_presses++;
		end
		prev_key9    = stim_keys[9];
		prev_mf      = stim_multiface;
		xfers_before = xfer_count;

		if (idx % 4 == 3)
		begin
			inject_glitches(used);
		end
		repeat (PHASE_CYCLES - used) @(posedge btn_patrons_s);

		check_pair("ctrl_data_o", last_xfer, expected_pair(stim_joy1, stim_joy2, stim_keys));
		check_bit("patrons_o", seen_patrons, patrons_presses[0]);
		check_bit("scandbl_o", seen_scandbl, multiface_presses[0]);
		if (idx % 4 == 3 && xfer_count != xfers_before)
		begin
			abort_run("a glitch phase produced a transfer");
		end
	endtask

	initial
	begin
		void'($urandom(32'h2ea));
		joyp_n          = '1;
		keyb_col        = '1;
		btn_multiface_n = 1'b1;
		stim_joy1       = '0;
		stim_joy2       = '0;
		stim_keys       = '0;
		stim_multiface  = 1'b0;
		glitch_joy1     = '0;
		glitch_joy2     = '0;
		glitch_keys     = '0;
		glitch_mf       = 1'b0;
		for (int i = 0; i < ACK_DELAYS; i++)
		begin
			ack_delay[i] = $urandom % 8;
		end

		wait (arst_n === 1'b1);
		@(posedge btn_patrons_s);
		monitor_on = 1'b1;
		repeat (4) @(posedge btn_patrons_s);

		for (int p = 0; p < NUM_PHASES; p++)
		begin
			run_phase(p);
		end

		if (xfer_count == 0)
		begin
			abort_run("no transfer completed during the run");
		end
		else
		begin
			$display("transfers completed: %0d", xfer_count);
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* arcade_ctrl_top.f */
common/arcade_ctrl_pkg.sv
ctrl_input/joy_mux_sampler.sv
ctrl_input/membrane_scanner.sv
src/debounce_filter.sv
src/control_merge.sv
ctrl_output/ctrl_word_sender.sv
src/arcade_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/arcade_ctrl_tb.sv
